// File: include/multdiv_params.svh
//##########################################################################
// Fixed 32-bit datapath built from two 16-bit operand halves
// Divider produces one quotient bit per cycle
//##########################################################################

`ifndef MULTDIV_PARAMS_SVH
`define MULTDIV_PARAMS_SVH

// Operand and result width
`define MD_DATA_W    32
// Half word fed to the 17x17 multiplier
`define MD_HALF_W    16
// Accumulator and partial remainder
`define MD_ACC_W     34
// Quotient bit counter
`define MD_CNT_W     5
`define MD_DIV_STEPS 32

`endif

// File: hdl/md_op_pkg.sv
//##########################################################################
// Operation and data word types shared by the whole unit
//##########################################################################

`default_nettype none

`include "multdiv_params.svh"

package md_op_pkg;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  typedef logic [`MD_DATA_W-1:0] md_word_t;

  // Bit 0 marks operand a as signed, bit 1 operand b
  typedef logic [1:0] md_sign_t;

endpackage

`default_nettype wire

// File: hdl/md_state_pkg.sv
//##########################################################################
// Sequencer states of the multiplier and the divider
//##########################################################################

`default_nettype none

package md_state_pkg;

  // Named after the operand halves multiplied in each step
  typedef enum logic [1:0] {ALBL, ALBH, AHBL, AHBH} mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

endpackage

`default_nettype wire

// File: hdl/md_unit_if.sv
//##########################################################################
// Request and result link between the top level and one arithmetic unit
// Inputs must stay stable while en is high until valid and ready meet
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

interface md_unit_if import md_op_pkg::*; ();

  logic     en;
  md_op_e   operator;
  md_sign_t signed_mode;
  md_word_t op_a;
  md_word_t op_b;
  logic     ready;
  md_word_t result;
  logic     valid;

  modport ctrl (
    output en, operator, signed_mode, op_a, op_b, ready,
    input  result, valid
  );

  modport unit (
    input  en, operator, signed_mode, op_a, op_b, ready,
    output result, valid
  );

endinterface

`default_nettype wire

// File: hdl/mult_mac16.sv
//##########################################################################
// Multiplier with one signed 17x17 multiply-add per cycle
// MUL is valid in the third cycle, MULH in the fourth
// Operands are read directly every cycle and must be held by the requester
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

`include "multdiv_params.svh"

module mult_mac16 import md_op_pkg::*, md_state_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  md_unit_if.unit md
);

  mult_state_e state_q;
  mult_state_e state_d;

  logic [`MD_HALF_W-1:0] a_lo;
  logic [`MD_HALF_W-1:0] a_hi;
  logic [`MD_HALF_W-1:0] b_lo;
  logic [`MD_HALF_W-1:0] b_hi;
  logic [`MD_HALF_W-1:0] mult_a;
  logic [`MD_HALF_W-1:0] mult_b;
  logic                  sign_a;
  logic                  sign_b;
  logic                  a_neg;
  logic                  b_neg;

  logic signed [`MD_ACC_W-1:0] mac_res;
  logic [`MD_ACC_W-1:0]        accum;
  logic [`MD_ACC_W-1:0]        mac_res_d;
  logic [`MD_ACC_W-1:0]        acc_q;

  logic mult_valid;
  logic mult_hold;
  logic en_int;

  assign a_lo = md.op_a[`MD_HALF_W-1:0];
  assign a_hi = md.op_a[`MD_DATA_W-1:`MD_HALF_W];
  assign b_lo = md.op_b[`MD_HALF_W-1:0];
  assign b_hi = md.op_b[`MD_DATA_W-1:`MD_HALF_W];

  // Sign of each high half as extension bit of the 17-bit operand
  assign a_neg = md.signed_mode[0] & md.op_a[`MD_DATA_W-1];
  assign b_neg = md.signed_mode[1] & md.op_b[`MD_DATA_W-1];

  // Top two bits of the sum always agree, so 34 bits hold it exactly
  assign mac_res = $signed({sign_a, mult_a}) * $signed({sign_b, mult_b}) + $signed(accum);

  always_comb begin
    mult_a     = a_lo;
    mult_b     = b_lo;
    sign_a     = 1'b0;
    sign_b     = 1'b0;
    accum      = '0;
    mac_res_d  = mac_res;
    state_d    = state_q;
    mult_valid = 1'b0;
    mult_hold  = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end
      ALBH: begin
        mult_b = b_hi;
        sign_b = b_neg;
        // AL*BL is unsigned and fits 32 bits
        accum  = {18'b0, acc_q[31:16]};
        if (md.operator == MD_OP_MULL) begin
          mac_res_d = {2'b0, mac_res[15:0], acc_q[15:0]};
        end
        state_d = AHBL;
      end
      AHBL: begin
        mult_a = a_hi;
        sign_a = a_neg;
        if (md.operator == MD_OP_MULL) begin
          accum      = {18'b0, acc_q[31:16]};
          mac_res_d  = {2'b0, mac_res[15:0], acc_q[15:0]};
          mult_valid = 1'b1;
          mult_hold  = ~md.ready;
          state_d    = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mult_a     = a_hi;
        mult_b     = b_hi;
        sign_a     = a_neg;
        sign_b     = b_neg;
        // Arithmetic shift of the 34-bit middle sum
        accum      = {{16{acc_q[33]}}, acc_q[33:16]};
        mult_valid = 1'b1;
        mult_hold  = ~md.ready;
        state_d    = ALBL;
      end
    endcase
  end

  // Holding the registers keeps the result stable under back-pressure
  assign en_int = md.en & ~mult_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      acc_q   <= '0;
    end else if (en_int) begin
      state_q <= state_d;
      acc_q   <= mac_res_d;
    end
  end

  assign md.result = mac_res_d[`MD_DATA_W-1:0];
  assign md.valid  = mult_valid;

  a_valid_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    md.valid |-> md.en);

  a_result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    md.valid && !md.ready |=> md.valid && $stable(md.result));

endmodule

`default_nettype wire

// File: hdl/div_long.sv
//##########################################################################
// Restoring long divider on absolute values with sign fix-up at the end
// Nonzero divisor takes 37 cycles to valid, zero divisor takes 2
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

`include "multdiv_params.svh"

module div_long import md_op_pkg::*, md_state_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  md_unit_if.unit md
);

  localparam logic [`MD_CNT_W-1:0] cnt_init = `MD_CNT_W'(`MD_DIV_STEPS - 1);

  div_state_e state_q;
  div_state_e state_d;

  logic [`MD_CNT_W-1:0]  cnt_q;
  logic [`MD_CNT_W-1:0]  cnt_d;
  logic [`MD_DATA_W-1:0] num_q;
  logic [`MD_DATA_W-1:0] num_d;
  logic [`MD_DATA_W-1:0] den_q;
  logic [`MD_DATA_W-1:0] den_d;
  logic [`MD_DATA_W-1:0] quo_q;
  logic [`MD_DATA_W-1:0] quo_d;
  logic [`MD_ACC_W-1:0]  rem_q;
  logic [`MD_ACC_W-1:0]  rem_d;

  logic [`MD_DATA_W-1:0] sub_x;
  logic [`MD_DATA_W-1:0] sub_y;
  logic [`MD_DATA_W:0]   sub_res;
  logic [`MD_DATA_W-1:0] next_rem;
  logic                  rem_ge;

  logic sign_a;
  logic sign_b;
  logic b_zero;
  logic div_valid;
  logic div_hold;
  logic en_int;

  assign sign_a = md.signed_mode[0] & md.op_a[`MD_DATA_W-1];
  assign sign_b = md.signed_mode[1] & md.op_b[`MD_DATA_W-1];
  assign b_zero = (md.op_b == '0);

  // Shared subtractor, the extra top bit is the borrow
  assign sub_res = {1'b0, sub_x} - {1'b0, sub_y};
  assign rem_ge  = ~sub_res[`MD_DATA_W];

  // Partial remainder always fits 32 bits before the compare
  assign next_rem = rem_ge ? sub_res[`MD_DATA_W-1:0] : rem_q[`MD_DATA_W-1:0];

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q - 1'b1;
    num_d     = num_q;
    den_d     = den_q;
    quo_d     = quo_q;
    rem_d     = rem_q;
    sub_x     = '0;
    sub_y     = '0;
    div_valid = 1'b0;
    div_hold  = 1'b0;

    unique case (state_q)
      DIV_IDLE: begin
        // Preload the zero divisor results for both DIV and REM
        quo_d   = '1;
        rem_d   = {2'b0, md.op_a};
        cnt_d   = cnt_init;
        state_d = b_zero ? DIV_FINISH : DIV_ABS_A;
      end
      DIV_ABS_A: begin
        sub_y   = md.op_a;
        num_d   = sign_a ? sub_res[`MD_DATA_W-1:0] : md.op_a;
        quo_d   = '0;
        cnt_d   = cnt_init;
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        sub_y   = md.op_b;
        den_d   = sign_b ? sub_res[`MD_DATA_W-1:0] : md.op_b;
        rem_d   = {33'b0, num_q[`MD_DATA_W-1]};
        cnt_d   = cnt_init;
        state_d = DIV_COMP;
      end
      DIV_COMP: begin
        sub_x   = rem_q[`MD_DATA_W-1:0];
        sub_y   = den_q;
        rem_d   = {1'b0, next_rem, num_q[cnt_d]};
        quo_d   = {quo_q[`MD_DATA_W-2:0], rem_ge};
        state_d = (cnt_q == `MD_CNT_W'(1)) ? DIV_LAST : DIV_COMP;
      end
      DIV_LAST: begin
        // Final bit, no numerator bit left to shift in
        sub_x   = rem_q[`MD_DATA_W-1:0];
        sub_y   = den_q;
        rem_d   = {2'b0, next_rem};
        quo_d   = {quo_q[`MD_DATA_W-2:0], rem_ge};
        state_d = DIV_SIGN;
      end
      DIV_SIGN: begin
        if (md.operator == MD_OP_DIV) begin
          sub_y = quo_q;
          quo_d = (sign_a ^ sign_b) ? sub_res[`MD_DATA_W-1:0] : quo_q;
        end else begin
          // Remainder takes the sign of the dividend
          sub_y = rem_q[`MD_DATA_W-1:0];
          rem_d = sign_a ? {2'b0, sub_res[`MD_DATA_W-1:0]} : rem_q;
        end
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        div_valid = 1'b1;
        div_hold  = ~md.ready;
        state_d   = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  assign en_int = md.en & ~div_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      num_q   <= '0;
      den_q   <= '0;
      quo_q   <= '0;
      rem_q   <= '0;
    end else if (en_int) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      num_q   <= num_d;
      den_q   <= den_d;
      quo_q   <= quo_d;
      rem_q   <= rem_d;
    end
  end

  assign md.result = (md.operator == MD_OP_DIV) ? quo_q : rem_q[`MD_DATA_W-1:0];
  assign md.valid  = div_valid;

  // A zero count here would end the bit loop early
  a_cnt_on_comp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(state_q == DIV_COMP) |-> cnt_q != '0);

endmodule

`default_nettype wire

// File: hdl/multdiv_top.sv
//##########################################################################
// Multiply/divide unit, request held until valid_o and ready_i meet
// Only one operation is in flight at a time
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module multdiv_top import md_op_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  md_op_e   operator_i,
  input  md_sign_t signed_mode_i,
  input  md_word_t op_a_i,
  input  md_word_t op_b_i,
  input  logic     ready_i,
  output md_word_t result_o,
  output logic     valid_o
);

  md_unit_if mult_if ();
  md_unit_if div_if ();

  // Operator class decides which unit runs
  assign mult_if.en = req_i & ((operator_i == MD_OP_MULL) | (operator_i == MD_OP_MULH));
  assign div_if.en  = req_i & ((operator_i == MD_OP_DIV) | (operator_i == MD_OP_REM));

  assign mult_if.operator    = operator_i;
  assign mult_if.signed_mode = signed_mode_i;
  assign mult_if.op_a        = op_a_i;
  assign mult_if.op_b        = op_b_i;
  assign mult_if.ready       = ready_i;

  assign div_if.operator    = operator_i;
  assign div_if.signed_mode = signed_mode_i;
  assign div_if.op_a        = op_a_i;
  assign div_if.op_b        = op_b_i;
  assign div_if.ready       = ready_i;

  mult_mac16 i_mult (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .md     (mult_if.unit)
  );

  div_long i_div (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .md     (div_if.unit)
  );

  assign result_o = div_if.valid ? div_if.result : mult_if.result;
  assign valid_o  = mult_if.valid | div_if.valid;

endmodule

`default_nettype wire

// File: verif/tb_multdiv.sv
//##########################################################################
// Testbench for the multiply/divide unit, one operation in flight at a time
// Concurrent assertions compare each result with a 64-bit reference model
// Operands stay on the inputs until the transfer, as the handshake requires
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module tb_multdiv import md_op_pkg::*;;

  localparam int clk_period = 4;
  localparam int n_bp_ops   = 12;
  localparam int max_stall  = 8;
  // mul and mulh, div and rem, overflow, zero divisor, back-pressure
  localparam int n_ops       = 48 + 20 + 2 + 8 + n_bp_ops;
  localparam int watchdog_ns = (n_ops * 40 + n_bp_ops * max_stall) * clk_period;

  logic     clk_i;
  logic     rst_ni;
  logic     req_i;
  md_op_e   operator_i;
  md_sign_t signed_mode_i;
  md_word_t op_a_i;
  md_word_t op_b_i;
  logic     ready_i;
  md_word_t result_o;
  logic     valid_o;

  md_word_t    exp_result;
  int          exp_lat;
  int          cyc_q;
  logic [31:0] lfsr_q;
  int          err_cnt;
  int          op_cnt;

  multdiv_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Number of the current cycle of the pending request, 1 on its first cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= 1;
    end else if (!req_i || (valid_o && ready_i)) begin
      cyc_q <= 1;
    end else begin
      cyc_q <= cyc_q + 1;
    end
  end

  a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni) !req_i |-> !valid_o)
    else begin
      err_cnt++;
      $display("ERR t=%0t valid_o expected 0 got 1", $time);
    end

  a_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> result_o == exp_result)
    else begin
      err_cnt++;
      $display("ERR t=%0t result_o expected %h got %h", $time,
               $sampled(exp_result), $sampled(result_o));
    end

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_o) |-> cyc_q == exp_lat)
    else begin
      err_cnt++;
      $display("ERR t=%0t valid_o rise cycle expected %0d got %0d", $time,
               $sampled(exp_lat), $sampled(cyc_q));
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o))
    else begin
      err_cnt++;
      $display("Result dropped or changed at t=%0t while ready_i was low", $time);
    end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // A quarter of the operands are corner values
  task automatic pick_operand(output md_word_t v);
    logic [31:0] sel;
    take_bits(4, sel);
    case (sel[3:0])
      4'd0:    v = '0;
      4'd1:    v = 32'd1;
      4'd2:    v = '1;
      4'd3:    v = 32'h8000_0000;
      default: take_bits(32, v);
    endcase
  endtask

  function automatic md_word_t expected_result(input md_op_e op, input md_sign_t mode,
                                               input md_word_t a, input md_word_t b);
    longint sa;
    longint sb;
    longint full;
    sa = mode[0] ? longint'($signed(a)) : longint'(a);
    sb = mode[1] ? longint'($signed(b)) : longint'(b);
    if (op == MD_OP_MULL || op == MD_OP_MULH) begin
      full = sa * sb;
      return (op == MD_OP_MULL) ? full[31:0] : full[63:32];
    end
    if (b == '0) begin
      return (op == MD_OP_DIV) ? '1 : a;
    end
    // Truncating division gives the RISC-V quotient and remainder signs
    full = (op == MD_OP_DIV) ? sa / sb : sa % sb;
    return full[31:0];
  endfunction

  function automatic int expected_latency(input md_op_e op, input md_word_t b);
    case (op)
      MD_OP_MULL: return 3;
      MD_OP_MULH: return 4;
      default:    return (b == '0) ? 2 : 37;
    endcase
  endfunction

  // Holds the request until the transfer, keeping ready_i low for stall cycles
  task automatic run_op(input md_op_e op, input md_sign_t mode, input md_word_t a,
                        input md_word_t b, input int stall);
    int   stalled;
    logic done;
    stalled       = 0;
    done          = 1'b0;
    req_i         = 1'b1;
    operator_i    = op;
    signed_mode_i = mode;
    op_a_i        = a;
    op_b_i        = b;
    ready_i       = (stall == 0);
    exp_result    = expected_result(op, mode, a, b);
    exp_lat       = expected_latency(op, b);
    while (!done) begin
      @(negedge clk_i);
      if (valid_o && ready_i) begin
        done = 1'b1;
      end else if (valid_o) begin
        stalled++;
      end
      @(posedge clk_i);
      #1;
      if (stalled >= stall) begin
        ready_i = 1'b1;
      end
    end
    op_cnt++;
  endtask

  task automatic drop_req();
    req_i   = 1'b0;
    ready_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input string name, input int ops0, input int errs0);
    $display("%-10s %0d operations, %0d errors", name, op_cnt - ops0, err_cnt - errs0);
  endtask

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired at %0t, an operation never completed", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    md_word_t    a;
    md_word_t    b;
    logic [31:0] bits;
    md_sign_t    mode;
    md_op_e      op;
    int          ops0;
    int          errs0;

    lfsr_q        = 32'd1868;
    err_cnt       = 0;
    op_cnt        = 0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = '0;
    op_a_i        = '0;
    op_b_i        = '0;
    ready_i       = 1'b0;
    exp_result    = '0;
    exp_lat       = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    errs0 = err_cnt;
    repeat (5) @(posedge clk_i);
    #1;
    report_test("reset", op_cnt, errs0);

    for (int k = 0; k < 2; k++) begin
      op    = k ? MD_OP_MULH : MD_OP_MULL;
      ops0  = op_cnt;
      errs0 = err_cnt;
      for (int m = 0; m < 4; m++) begin
        for (int n = 0; n < 6; n++) begin
          pick_operand(a);
          pick_operand(b);
          run_op(op, md_sign_t'(m), a, b, 0);
          drop_req();
        end
      end
      report_test(k ? "mulh" : "mul", ops0, errs0);
    end

    ops0  = op_cnt;
    errs0 = err_cnt;
    for (int m = 0; m < 2; m++) begin
      mode = m ? 2'b11 : 2'b00;
      for (int k = 0; k < 2; k++) begin
        op = k ? MD_OP_REM : MD_OP_DIV;
        for (int n = 0; n < 5; n++) begin
          pick_operand(a);
          pick_operand(b);
          run_op(op, mode, a, b, 0);
          drop_req();
        end
      end
    end
    // Most negative value divided by minus one
    run_op(MD_OP_DIV, 2'b11, 32'h8000_0000, '1, 0);
    drop_req();
    run_op(MD_OP_REM, 2'b11, 32'h8000_0000, '1, 0);
    drop_req();
    report_test("div/rem", ops0, errs0);

    ops0  = op_cnt;
    errs0 = err_cnt;
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 2; k++) begin
        pick_operand(a);
        run_op(k ? MD_OP_REM : MD_OP_DIV, md_sign_t'(m), a, '0, 0);
        drop_req();
      end
    end
    report_test("div-zero", ops0, errs0);

    // Back-to-back requests, each result stalled for 1 to 8 cycles
    ops0  = op_cnt;
    errs0 = err_cnt;
    for (int n = 0; n < n_bp_ops; n++) begin
      take_bits(2, bits);
      op = md_op_e'(bits[1:0]);
      take_bits(2, bits);
      mode = bits[1:0];
      pick_operand(a);
      pick_operand(b);
      take_bits(3, bits);
      run_op(op, mode, a, b, int'(bits[2:0]) + 1);
    end
    drop_req();
    report_test("stall", ops0, errs0);

    $display("Total %0d operations, %0d errors", op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: multdiv_top.f
+incdir+include
hdl/md_op_pkg.sv
hdl/md_state_pkg.sv
hdl/md_unit_if.sv
hdl/mult_mac16.sv
hdl/div_long.sv
hdl/multdiv_top.sv
verif/tb_multdiv.sv

// File: Makefile
# Verilator build and run of the multiply/divide testbench

VERILATOR ?= verilator
TOP       ?= tb_multdiv
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST := multdiv_top.f
SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
